//--- Bender.yml
package:
  name: arc_io

sources:
  - files:
      - common/arc_pkg.sv
      - src/bus_router.sv
      - src/mem_bridge.sv
      - ioc/ioc_irq.sv
      - ioc/ioc_regs.sv
      - src/ext_latches.sv
      - src/arc_io_top.sv
  - target: test
    files:
      - test/tb_arc_io.sv

//--- common/arc_pkg.sv
`default_nettype none

package arc_pkg;

	// word request from the cpu bus
	typedef struct packed {
		logic [25:2] addr;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        err;
	} cpu_rsp_t;

	// external memory port request, 16 MB window
	typedef struct packed {
		logic [23:2] addr;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] wdata;
	} mem_req_t;

	// byte wide register access, data from cpu bits 23:16
	typedef struct packed {
		logic       stb;
		logic       we;
		logic [4:0] idx;
		logic [2:0] bank;
		logic [7:0] wdata;
	} reg_req_t;

	typedef enum logic [1:0] {
		TGT_RAM,
		TGT_IOC,
		TGT_LATCH,
		TGT_NONE
	} target_e;

	typedef enum logic [4:0] {
		REG_CTRL      = 5'd0,
		REG_KBD       = 5'd1,
		REG_IRQA_STAT = 5'd4,
		REG_IRQA_REQ  = 5'd5,
		REG_IRQA_MASK = 5'd6,
		REG_IRQB_STAT = 5'd8,
		REG_IRQB_REQ  = 5'd9,
		REG_IRQB_MASK = 5'd10,
		REG_FIQ_STAT  = 5'd12,
		REG_FIQ_REQ   = 5'd13,
		REG_FIQ_MASK  = 5'd14
	} ioc_reg_e;

	// floating bus reads back as all ones
	localparam logic [31:0] UNMAPPED_DATA = 32'hffff_ffff;

	// address bits 25:24 of i/o space
	localparam logic [1:0] IO_REGION = 2'b11;

endpackage

`default_nettype wire

//--- ioc/ioc_irq.sv
`default_nettype none

module ioc_irq #(
	parameter int FLYBK_SYNC_STAGES = 2
) (
	input  wire                 clkcpu_i,
	input  wire                 rst_i,
	input  arc_pkg::reg_req_t   reg_i,
	input  wire                 flybk_i,
	input  wire                 rx_full_i,
	input  wire                 tx_empty_i,
	input  wire                 floppy_drq_i,
	input  wire                 floppy_irq_i,
	output logic [7:0]          stat_a_o,
	output logic [7:0]          stat_b_o,
	output logic [7:0]          stat_f_o,
	output logic [7:0]          mask_a_o,
	output logic [7:0]          mask_b_o,
	output logic [7:0]          mask_f_o,
	output logic                irq_o,
	output logic                firq_o
);

	logic [FLYBK_SYNC_STAGES-1:0] sync_q;
	logic                         flyb_prev_q;
	logic                         flyb_rise;
	logic                         flyb_ev_q;
	logic                         por_q;
	logic                         wr;

	assign wr = reg_i.stb & reg_i.we;
	assign flyb_rise = sync_q[FLYBK_SYNC_STAGES-1] & ~flyb_prev_q;

	always_ff @(posedge clkcpu_i) begin
		if (rst_i) begin
			sync_q <= '0;
			flyb_prev_q <= 1'b0;
			flyb_ev_q <= 1'b0;
			por_q <= 1'b1;
			mask_a_o <= 8'h00;
			mask_b_o <= 8'h00;
			mask_f_o <= 8'h00;
			irq_o <= 1'b0;
			firq_o <= 1'b0;
		end else begin
			// flyback comes from the video clock domain
			sync_q[0] <= flybk_i;
			for (int i = 1; i < FLYBK_SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
			flyb_prev_q <= sync_q[FLYBK_SYNC_STAGES-1];

			if (flyb_rise)
				flyb_ev_q <= 1'b1;
			else if (wr && reg_i.idx == arc_pkg::REG_IRQA_REQ && reg_i.wdata[3])
				flyb_ev_q <= 1'b0;
			if (wr && reg_i.idx == arc_pkg::REG_IRQA_REQ && reg_i.wdata[4])
				por_q <= 1'b0;

			if (wr && reg_i.idx == arc_pkg::REG_IRQA_MASK)
				mask_a_o <= reg_i.wdata;
			if (wr && reg_i.idx == arc_pkg::REG_IRQB_MASK)
				mask_b_o <= reg_i.wdata;
			if (wr && reg_i.idx == arc_pkg::REG_FIQ_MASK)
				mask_f_o <= reg_i.wdata;

			irq_o <= |(stat_a_o & mask_a_o) | |(stat_b_o & mask_b_o);
			firq_o <= |(stat_f_o & mask_f_o);
		end
	end

	// power-on in bit 4, vertical flyback in bit 3
	assign stat_a_o = {3'b000, por_q, flyb_ev_q, 3'b000};
	assign stat_b_o = {rx_full_i, tx_empty_i, 6'b00_0000};
	assign stat_f_o = {6'b00_0000, floppy_irq_i, floppy_drq_i};

endmodule

`default_nettype wire

//--- ioc/ioc_regs.sv
`default_nettype none

module ioc_regs #(
	parameter int FLYBK_SYNC_STAGES = 2
) (
	input  wire                 clkcpu_i,
	input  wire                 rst_i,
	input  arc_pkg::reg_req_t   reg_i,
	output logic [7:0]          rdata_o,

	input  wire                 flybk_i,
	input  wire                 floppy_drq_i,
	input  wire                 floppy_irq_i,

	input  wire [7:0]           kbd_in_data_i,
	input  wire                 kbd_in_strobe_i,
	output logic [7:0]          kbd_out_data_o,
	output logic                kbd_out_strobe_o,

	input  wire                 i2c_din_i,
	output logic                i2c_clock_o,
	output logic                i2c_dout_o,
	output logic                irq_o,
	output logic                firq_o
);

	arc_pkg::reg_req_t reg_int;
	logic              wr;
	logic              rd;
	logic [5:0]        ctrl_q;
	logic [7:0]        rx_data_q;
	logic              rx_full_q;
	logic [7:0]        stat_a, stat_b, stat_f;
	logic [7:0]        mask_a, mask_b, mask_f;
	logic [7:0]        rd_mux;

	// only bank 0 holds the internal registers
	always_comb begin
		reg_int = reg_i;
		reg_int.stb = reg_i.stb & (reg_i.bank == 3'd0);
	end

	assign wr = reg_int.stb & reg_int.we;
	assign rd = reg_int.stb & ~reg_int.we;

	always_ff @(posedge clkcpu_i) begin
		if (rst_i) begin
			ctrl_q <= 6'h3f;
			rx_full_q <= 1'b0;
			kbd_out_strobe_o <= 1'b0;
		end else begin
			kbd_out_strobe_o <= 1'b0;
			if (wr && reg_int.idx == arc_pkg::REG_CTRL)
				ctrl_q <= reg_int.wdata[5:0];
			if (wr && reg_int.idx == arc_pkg::REG_KBD)
				kbd_out_strobe_o <= 1'b1;
			// a new byte wins over the read that clears
			if (kbd_in_strobe_i)
				rx_full_q <= 1'b1;
			else if (rd && reg_int.idx == arc_pkg::REG_KBD)
				rx_full_q <= 1'b0;
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (kbd_in_strobe_i)
			rx_data_q <= kbd_in_data_i;
		if (wr && reg_int.idx == arc_pkg::REG_KBD)
			kbd_out_data_o <= reg_int.wdata;
		if (rd)
			rdata_o <= rd_mux;
	end

	assign i2c_clock_o = ctrl_q[1];
	assign i2c_dout_o = ctrl_q[0];

	always_comb begin
		case (arc_pkg::ioc_reg_e'(reg_int.idx))
			arc_pkg::REG_CTRL:      rd_mux = {2'b11, ctrl_q[5:2], i2c_clock_o, i2c_din_i};
			arc_pkg::REG_KBD:       rd_mux = rx_data_q;
			arc_pkg::REG_IRQA_STAT: rd_mux = stat_a;
			arc_pkg::REG_IRQA_REQ:  rd_mux = stat_a & mask_a;
			arc_pkg::REG_IRQA_MASK: rd_mux = mask_a;
			arc_pkg::REG_IRQB_STAT: rd_mux = stat_b;
			arc_pkg::REG_IRQB_REQ:  rd_mux = stat_b & mask_b;
			arc_pkg::REG_IRQB_MASK: rd_mux = mask_b;
			arc_pkg::REG_FIQ_STAT:  rd_mux = stat_f;
			arc_pkg::REG_FIQ_REQ:   rd_mux = stat_f & mask_f;
			arc_pkg::REG_FIQ_MASK:  rd_mux = mask_f;
			default:                rd_mux = 8'hff;
		endcase
	end

	ioc_irq #(
		.FLYBK_SYNC_STAGES (FLYBK_SYNC_STAGES)
	) u_irq (
		.clkcpu_i     (clkcpu_i),
		.rst_i        (rst_i),
		.reg_i        (reg_int),
		.flybk_i      (flybk_i),
		.rx_full_i    (rx_full_q),
		// controller takes the byte on the strobe
		.tx_empty_i   (~kbd_out_strobe_o),
		.floppy_drq_i (floppy_drq_i),
		.floppy_irq_i (floppy_irq_i),
		.stat_a_o     (stat_a),
		.stat_b_o     (stat_b),
		.stat_f_o     (stat_f),
		.mask_a_o     (mask_a),
		.mask_b_o     (mask_b),
		.mask_f_o     (mask_f),
		.irq_o        (irq_o),
		.firq_o       (firq_o)
	);

endmodule

`default_nettype wire

//--- project.f
common/arc_pkg.sv
src/bus_router.sv
src/mem_bridge.sv
ioc/ioc_irq.sv
ioc/ioc_regs.sv
src/ext_latches.sv
src/arc_io_top.sv
test/tb_arc_io.sv

//--- src/arc_io_top.sv
`default_nettype none

module arc_io_top #(
	parameter int FLYBK_SYNC_STAGES = 2
) (
	input  wire                 clkcpu_i,
	input  wire                 rst_i,

	// cpu bus
	input  arc_pkg::cpu_req_t   cpu_req_i,
	input  wire                 cpu_valid_i,
	output logic                cpu_ready_o,
	output arc_pkg::cpu_rsp_t   cpu_rsp_o,
	output logic                cpu_rsp_valid_o,

	// external memory
	output arc_pkg::mem_req_t   mem_req_o,
	output logic                mem_valid_o,
	input  wire                 mem_ready_i,
	input  wire [31:0]          mem_rdata_i,
	input  wire                 mem_err_i,
	input  wire                 mem_rsp_valid_i,

	input  wire                 flybk_i,
	input  wire                 floppy_drq_i,
	input  wire                 floppy_irq_i,

	input  wire [7:0]           kbd_in_data_i,
	input  wire                 kbd_in_strobe_i,
	output logic [7:0]          kbd_out_data_o,
	output logic                kbd_out_strobe_o,

	input  wire                 i2c_din_i,
	output logic                i2c_clock_o,
	output logic                i2c_dout_o,

	input  wire [4:0]           joy0_i,
	input  wire [4:0]           joy1_i,

	output logic [1:0]          vidbaseclk_o,
	output logic [1:0]          vidsyncpol_o,
	output logic                debug_led_o,
	output logic                irq_o,
	output logic                firq_o
);

	arc_pkg::cpu_req_t ram_req;
	logic              ram_valid;
	logic              ram_ready;
	arc_pkg::cpu_rsp_t ram_rsp;
	logic              ram_rsp_valid;

	arc_pkg::reg_req_t ioc_req;
	logic [7:0]        ioc_rdata;
	arc_pkg::reg_req_t latch_req;
	logic [7:0]        latch_rdata;

	bus_router u_router (
		.clkcpu_i        (clkcpu_i),
		.rst_i           (rst_i),
		.cpu_req_i       (cpu_req_i),
		.cpu_valid_i     (cpu_valid_i),
		.cpu_ready_o     (cpu_ready_o),
		.cpu_rsp_o       (cpu_rsp_o),
		.cpu_rsp_valid_o (cpu_rsp_valid_o),
		.ram_req_o       (ram_req),
		.ram_valid_o     (ram_valid),
		.ram_ready_i     (ram_ready),
		.ram_rsp_i       (ram_rsp),
		.ram_rsp_valid_i (ram_rsp_valid),
		.ioc_req_o       (ioc_req),
		.ioc_rdata_i     (ioc_rdata),
		.latch_req_o     (latch_req),
		.latch_rdata_i   (latch_rdata)
	);

	mem_bridge u_bridge (
		.clkcpu_i        (clkcpu_i),
		.rst_i           (rst_i),
		.ram_req_i       (ram_req),
		.ram_valid_i     (ram_valid),
		.ram_ready_o     (ram_ready),
		.ram_rsp_o       (ram_rsp),
		.ram_rsp_valid_o (ram_rsp_valid),
		.mem_req_o       (mem_req_o),
		.mem_valid_o     (mem_valid_o),
		.mem_ready_i     (mem_ready_i),
		.mem_rdata_i     (mem_rdata_i),
		.mem_err_i       (mem_err_i),
		.mem_rsp_valid_i (mem_rsp_valid_i)
	);

	ioc_regs #(
		.FLYBK_SYNC_STAGES (FLYBK_SYNC_STAGES)
	) u_ioc (
		.clkcpu_i         (clkcpu_i),
		.rst_i            (rst_i),
		.reg_i            (ioc_req),
		.rdata_o          (ioc_rdata),
		.flybk_i          (flybk_i),
		.floppy_drq_i     (floppy_drq_i),
		.floppy_irq_i     (floppy_irq_i),
		.kbd_in_data_i    (kbd_in_data_i),
		.kbd_in_strobe_i  (kbd_in_strobe_i),
		.kbd_out_data_o   (kbd_out_data_o),
		.kbd_out_strobe_o (kbd_out_strobe_o),
		.i2c_din_i        (i2c_din_i),
		.i2c_clock_o      (i2c_clock_o),
		.i2c_dout_o       (i2c_dout_o),
		.irq_o            (irq_o),
		.firq_o           (firq_o)
	);

	ext_latches u_latches (
		.clkcpu_i     (clkcpu_i),
		.rst_i        (rst_i),
		.reg_i        (latch_req),
		.rdata_o      (latch_rdata),
		.joy0_i       (joy0_i),
		.joy1_i       (joy1_i),
		.vidbaseclk_o (vidbaseclk_o),
		.vidsyncpol_o (vidsyncpol_o),
		.debug_led_o  (debug_led_o)
	);

endmodule

`default_nettype wire

//--- src/bus_router.sv
`default_nettype none

module bus_router (
	input  wire                 clkcpu_i,
	input  wire                 rst_i,

	input  arc_pkg::cpu_req_t   cpu_req_i,
	input  wire                 cpu_valid_i,
	output logic                cpu_ready_o,
	output arc_pkg::cpu_rsp_t   cpu_rsp_o,
	output logic                cpu_rsp_valid_o,

	output arc_pkg::cpu_req_t   ram_req_o,
	output logic                ram_valid_o,
	input  wire                 ram_ready_i,
	input  arc_pkg::cpu_rsp_t   ram_rsp_i,
	input  wire                 ram_rsp_valid_i,

	output arc_pkg::reg_req_t   ioc_req_o,
	input  wire [7:0]           ioc_rdata_i,
	output arc_pkg::reg_req_t   latch_req_o,
	input  wire [7:0]           latch_rdata_i
);

	typedef enum logic [1:0] {
		IDLE,
		REG_WAIT,
		RAM_WAIT,
		RESPOND
	} state_e;

	state_e            state_q;
	arc_pkg::target_e  tgt_q;
	arc_pkg::cpu_req_t req_q;
	arc_pkg::cpu_rsp_t rsp_q;
	logic              reg_phase_q;
	logic              ram_sent_q;
	logic              accept;
	logic              strobe;
	arc_pkg::reg_req_t reg_req;

	function automatic arc_pkg::target_e decode(input logic [25:2] addr);
		if (addr[25:24] != arc_pkg::IO_REGION)
			return arc_pkg::TGT_RAM;
		if (addr[21] && addr[18:16] == 3'd0)
			return arc_pkg::TGT_IOC;
		// external latches sit in bank 5 at sync speed
		if (addr[21] && addr[18:16] == 3'd5 && addr[20:19] == 2'd2)
			return arc_pkg::TGT_LATCH;
		return arc_pkg::TGT_NONE;
	endfunction

	assign cpu_ready_o = (state_q == IDLE);
	assign accept = cpu_valid_i & cpu_ready_o;

	always_ff @(posedge clkcpu_i) begin
		if (rst_i) begin
			state_q <= IDLE;
			reg_phase_q <= 1'b0;
			ram_sent_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					reg_phase_q <= 1'b0;
					ram_sent_q <= 1'b0;
					if (accept)
						state_q <= (decode(cpu_req_i.addr) == arc_pkg::TGT_RAM) ? RAM_WAIT : REG_WAIT;
				end
				REG_WAIT: begin
					// first cycle strobes, second sees the read byte
					reg_phase_q <= 1'b1;
					if (reg_phase_q)
						state_q <= RESPOND;
				end
				RAM_WAIT: begin
					if (ram_valid_o && ram_ready_i)
						ram_sent_q <= 1'b1;
					if (ram_rsp_valid_i)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (accept) begin
			req_q <= cpu_req_i;
			tgt_q <= decode(cpu_req_i.addr);
		end
		if (state_q == REG_WAIT && reg_phase_q) begin
			rsp_q.err <= 1'b0;
			case (tgt_q)
				arc_pkg::TGT_IOC:   rsp_q.rdata <= {24'd0, ioc_rdata_i};
				arc_pkg::TGT_LATCH: rsp_q.rdata <= {24'd0, latch_rdata_i};
				default:            rsp_q.rdata <= arc_pkg::UNMAPPED_DATA;
			endcase
		end
	end

	// one shared register access, strobe steered to the decoded block
	assign strobe = (state_q == REG_WAIT) & ~reg_phase_q;

	always_comb begin
		reg_req.stb = 1'b0;
		reg_req.we = req_q.we;
		reg_req.idx = req_q.addr[6:2];
		reg_req.bank = req_q.addr[18:16];
		reg_req.wdata = req_q.wdata[23:16];
		ioc_req_o = reg_req;
		latch_req_o = reg_req;
		ioc_req_o.stb = strobe & (tgt_q == arc_pkg::TGT_IOC);
		latch_req_o.stb = strobe & (tgt_q == arc_pkg::TGT_LATCH);
	end

	assign ram_req_o = req_q;
	assign ram_valid_o = (state_q == RAM_WAIT) & ~ram_sent_q;

	// ram answers pass straight through, already registered in the bridge
	assign cpu_rsp_valid_o = (state_q == RESPOND) | ((state_q == RAM_WAIT) & ram_rsp_valid_i);
	assign cpu_rsp_o = (state_q == RAM_WAIT) ? ram_rsp_i : rsp_q;

endmodule

`default_nettype wire

//--- src/ext_latches.sv
`default_nettype none

module ext_latches (
	input  wire                 clkcpu_i,
	input  wire                 rst_i,
	input  arc_pkg::reg_req_t   reg_i,
	output logic [7:0]          rdata_o,
	input  wire [4:0]           joy0_i,
	input  wire [4:0]           joy1_i,
	output logic [1:0]          vidbaseclk_o,
	output logic [1:0]          vidsyncpol_o,
	output logic                debug_led_o
);

	// latch a
	// 3:0 drive selects, 4 side, 5 motor, 6 in-use, selects and in-use active low
	logic [6:0] latch_a_q;
	// latch c, enhancer clock and sync polarity
	logic [3:0] latch_c_q;
	logic       wr;
	logic       rd;

	assign wr = reg_i.stb & reg_i.we;
	assign rd = reg_i.stb & ~reg_i.we;

	always_ff @(posedge clkcpu_i) begin
		if (rst_i) begin
			latch_a_q <= 7'h7f;
			latch_c_q <= 4'h0;
		end else begin
			if (wr && reg_i.idx == 5'd0)
				latch_a_q <= reg_i.wdata[6:0];
			if (wr && reg_i.idx == 5'd2)
				latch_c_q <= reg_i.wdata[3:0];
		end
	end

	// joystick lines with the unused top bits floating high
	always_ff @(posedge clkcpu_i) begin
		if (rd) begin
			case (reg_i.idx)
				5'd0:    rdata_o <= {3'b111, joy0_i};
				5'd1:    rdata_o <= {3'b111, joy1_i};
				default: rdata_o <= 8'hff;
			endcase
		end
	end

	assign vidbaseclk_o = latch_c_q[1:0];
	assign vidsyncpol_o = latch_c_q[3:2];

	// floppy activity
	assign debug_led_o = ~latch_a_q[0] | ~latch_a_q[6];

endmodule

`default_nettype wire

//--- src/mem_bridge.sv
`default_nettype none

module mem_bridge (
	input  wire                 clkcpu_i,
	input  wire                 rst_i,

	input  arc_pkg::cpu_req_t   ram_req_i,
	input  wire                 ram_valid_i,
	output logic                ram_ready_o,
	output arc_pkg::cpu_rsp_t   ram_rsp_o,
	output logic                ram_rsp_valid_o,

	output arc_pkg::mem_req_t   mem_req_o,
	output logic                mem_valid_o,
	input  wire                 mem_ready_i,
	input  wire [31:0]          mem_rdata_i,
	input  wire                 mem_err_i,
	input  wire                 mem_rsp_valid_i
);

	logic busy_q;

	// one access at a time
	assign ram_ready_o = ~busy_q;

	always_ff @(posedge clkcpu_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			mem_valid_o <= 1'b0;
			ram_rsp_valid_o <= 1'b0;
		end else begin
			ram_rsp_valid_o <= 1'b0;
			if (ram_valid_i && ram_ready_o) begin
				busy_q <= 1'b1;
				mem_valid_o <= 1'b1;
			end
			// request stays up until memory takes it
			if (mem_valid_o && mem_ready_i)
				mem_valid_o <= 1'b0;
			if (busy_q && mem_rsp_valid_i) begin
				busy_q <= 1'b0;
				ram_rsp_valid_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (ram_valid_i && ram_ready_o) begin
			mem_req_o.addr <= ram_req_i.addr[23:2];
			mem_req_o.we <= ram_req_i.we;
			mem_req_o.sel <= ram_req_i.sel;
			mem_req_o.wdata <= ram_req_i.wdata;
		end
		if (busy_q && mem_rsp_valid_i) begin
			ram_rsp_o.rdata <= mem_rdata_i;
			ram_rsp_o.err <= mem_err_i;
		end
	end

endmodule

`default_nettype wire

//--- test/arc_io_trace.txt
# W addr wdata | R addr rdata err | F | K byte | J joy0 joy1 | D drq irq | I irq firq
# O baseclk syncpol led i2c_clk i2c_dout | T tx_byte   (all values hex, byte addresses)
# masks and outputs after reset
R 3200018 00000000 0
R 3200028 00000000 0
R 3200038 00000000 0
I 0 0
O 0 0 0 1 1
# ram under random back-pressure
W 0000100 12345678
W 0000104 cafef00d
W 0000ffc 0badc0de
R 0000100 12345678 0
R 0000ffc 0badc0de 0
R 0000104 cafef00d 0
R 0000200 c0de0080 0
R 0f00010 00000000 1
# unmapped space
R 3000000 ffffffff 0
R 3250000 ffffffff 0
W 3100000 00000000
R 3100000 ffffffff 0
O 0 0 0 1 1
# control port
W 3200000 002a0000
O 0 0 0 1 0
R 3200000 000000eb 0
W 3200000 00010000
O 0 0 0 0 1
R 3200000 000000c1 0
# latches and joysticks
W 3350000 007e0000
W 3350008 000b0000
O 3 2 1 0 1
W 3350000 003f0000
O 3 2 1 0 1
W 3350000 007f0000
O 3 2 0 0 1
J 15 0a
R 3350000 000000f5 0
R 3350004 000000ea 0
# flyback
W 3200018 00080000
F
I 1 0
R 3200014 00000008 0
W 3200014 00080000
I 0 0
# floppy data request
W 3200038 00010000
D 1 0
I 0 1
D 0 0
I 0 0
# keyboard
W 3200028 00800000
K 5c
I 1 0
R 3200020 000000c0 0
R 3200004 0000005c 0
R 3200020 00000040 0
I 0 0
W 3200004 00a70000
T a7

//--- test/tb_arc_io.sv
`default_nettype none

module tb_arc_io;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SYNC_STAGES = 3;
	localparam int CYCLES_PER_LINE = 40;
	localparam int MEM_WORDS = 1024;
	localparam logic [31:0] RNG_SEED = 32'h6065;

	logic clk = 1'b0;
	logic rst;

	arc_pkg::cpu_req_t cpu_req;
	logic              cpu_valid;
	logic              cpu_ready;
	arc_pkg::cpu_rsp_t cpu_rsp;
	logic              cpu_rsp_valid;
	arc_pkg::mem_req_t mem_req;
	logic              mem_valid;
	logic              mem_ready;
	logic [31:0]       mem_rdata;
	logic              mem_err;
	logic              mem_rsp_valid;
	logic              flybk;
	logic              floppy_drq;
	logic              floppy_irq;
	logic [7:0]        kbd_in_data;
	logic              kbd_in_strobe;
	logic [7:0]        kbd_out_data;
	logic              kbd_out_strobe;
	logic              i2c_din;
	logic              i2c_clock;
	logic              i2c_dout;
	logic [4:0]        joy0;
	logic [4:0]        joy1;
	logic [1:0]        vidbaseclk;
	logic [1:0]        vidsyncpol;
	logic              debug_led;
	logic              irq;
	logic              firq;

	int err_rsp = 0;
	int err_irq = 0;
	int err_out = 0;
	int err_kbd = 0;
	int err_proto = 0;
	int trace_lines = 0;
	int tx_strobes = 0;
	logic [7:0] last_tx = 8'h00;

	// memory model state
	logic [31:0]       mem_model [0:MEM_WORDS-1];
	arc_pkg::mem_req_t held;
	logic              pend;
	int                lat_cnt;

	always #10 clk = ~clk;

	arc_io_top #(
		.FLYBK_SYNC_STAGES (SYNC_STAGES)
	) dut0 (
		.clkcpu_i         (clk),
		.rst_i            (rst),
		.cpu_req_i        (cpu_req),
		.cpu_valid_i      (cpu_valid),
		.cpu_ready_o      (cpu_ready),
		.cpu_rsp_o        (cpu_rsp),
		.cpu_rsp_valid_o  (cpu_rsp_valid),
		.mem_req_o        (mem_req),
		.mem_valid_o      (mem_valid),
		.mem_ready_i      (mem_ready),
		.mem_rdata_i      (mem_rdata),
		.mem_err_i        (mem_err),
		.mem_rsp_valid_i  (mem_rsp_valid),
		.flybk_i          (flybk),
		.floppy_drq_i     (floppy_drq),
		.floppy_irq_i     (floppy_irq),
		.kbd_in_data_i    (kbd_in_data),
		.kbd_in_strobe_i  (kbd_in_strobe),
		.kbd_out_data_o   (kbd_out_data),
		.kbd_out_strobe_o (kbd_out_strobe),
		.i2c_din_i        (i2c_din),
		.i2c_clock_o      (i2c_clock),
		.i2c_dout_o       (i2c_dout),
		.joy0_i           (joy0),
		.joy1_i           (joy1),
		.vidbaseclk_o     (vidbaseclk),
		.vidsyncpol_o     (vidsyncpol),
		.debug_led_o      (debug_led),
		.irq_o            (irq),
		.firq_o           (firq)
	);

	// external memory with random ready and 1 to 4 cycles of latency
	initial begin
		void'($urandom(RNG_SEED));
		for (int i = 0; i < MEM_WORDS; i++)
			mem_model[i] = 32'hc0de_0000 | i;
		pend = 1'b0;
		lat_cnt = 0;
		mem_ready <= 1'b0;
		mem_rdata <= 32'h0;
		mem_err <= 1'b0;
		mem_rsp_valid <= 1'b0;
		forever begin
			@(posedge clk);
			mem_rsp_valid <= 1'b0;
			if (rst) begin
				mem_ready <= 1'b0;
				pend = 1'b0;
			end else if (pend) begin
				lat_cnt = lat_cnt - 1;
				if (lat_cnt == 0) begin
					pend = 1'b0;
					mem_rsp_valid <= 1'b1;
					// top megabyte has no memory fitted
					if (held.addr[23:20] == 4'hf) begin
						mem_err <= 1'b1;
						mem_rdata <= 32'h0;
					end else begin
						mem_err <= 1'b0;
						mem_rdata <= held.we ? 32'h0 : mem_model[held.addr[11:2]];
					end
				end
			end else if (mem_valid && mem_ready) begin
				held = mem_req;
				if (held.we && held.addr[23:20] != 4'hf) begin
					for (int b = 0; b < 4; b++)
						if (held.sel[b])
							mem_model[held.addr[11:2]][8*b +: 8] = held.wdata[8*b +: 8];
				end
				lat_cnt = 1 + ($urandom % 4);
				pend = 1'b1;
				mem_ready <= 1'b0;
			end else begin
				mem_ready <= ($urandom % 2) != 0;
			end
		end
	end

	// transmit byte capture
	always @(posedge clk) begin
		if (kbd_out_strobe === 1'b1) begin
			tx_strobes = tx_strobes + 1;
			last_tx = kbd_out_data;
		end
	end

	task automatic print_counts();
		$display("errors: rsp %0d irq %0d outputs %0d kbd %0d protocol %0d",
			err_rsp, err_irq, err_out, err_kbd, err_proto);
	endtask

	task automatic check_rsp(input arc_pkg::cpu_rsp_t got, input arc_pkg::cpu_rsp_t exp,
			input logic [31:0] addr);
		if (got !== exp) begin
			err_rsp++;
			$display("ERROR cpu_rsp_o at %h: rdata got %h expected %h, err got %h expected %h",
				addr, got.rdata, exp.rdata, got.err, exp.err);
		end
	endtask

	task automatic check_irq(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			err_irq++;
			$display("ERROR {irq_o, firq_o} got %h expected %h", got, exp);
		end
	endtask

	task automatic check_outputs(input logic [6:0] got, input logic [6:0] exp);
		if (got !== exp) begin
			err_out++;
			$write("ERROR {vidbaseclk_o, vidsyncpol_o, debug_led_o, i2c_clock_o, i2c_dout_o}");
			$display(" got %h expected %h", got, exp);
		end
	endtask

	task automatic check_kbd(input logic [7:0] got, input logic [7:0] exp, input int strobes);
		if (got !== exp) begin
			err_kbd++;
			$display("ERROR kbd_out_data_o got %h expected %h", got, exp);
		end
		if (strobes != 1) begin
			err_kbd++;
			$display("ERROR kbd_out_strobe_o pulses got %h expected %h", strobes, 1);
		end
	endtask

	// {cpu_ready_o, cpu_rsp_valid_o, mem_valid_o, kbd_out_strobe_o}
	task automatic check_reset_state(input logic [3:0] got);
		if (got !== 4'b1000) begin
			err_proto++;
			$write("ERROR {cpu_ready_o, cpu_rsp_valid_o, mem_valid_o, kbd_out_strobe_o}");
			$display(" got %h expected %h", got, 4'b1000);
		end
	endtask

	task automatic bus_access(input logic [31:0] addr, input logic we, input logic [31:0] wdata,
			output arc_pkg::cpu_rsp_t rsp);
		arc_pkg::cpu_req_t req;
		int cycles;
		req.addr = addr[25:2];
		req.we = we;
		req.sel = 4'hf;
		req.wdata = wdata;
		@(posedge clk);
		cpu_req <= req;
		cpu_valid <= 1'b1;
		@(negedge clk);
		while (!cpu_ready)
			@(negedge clk);
		// taken on this edge
		@(posedge clk);
		cpu_valid <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cpu_ready) begin
				err_proto++;
				$display("cpu_ready_o was high while a request at %h was in flight", addr);
			end
		end while (!cpu_rsp_valid);
		rsp = cpu_rsp;
		// i/o space answers a fixed 2 cycles after the accepting edge
		if (addr[25:24] == 2'b11 && cycles - 1 != 2) begin
			err_proto++;
			$display("access at %h answered after %0d cycles instead of 2", addr, cycles - 1);
		end
		@(negedge clk);
		if (cpu_rsp_valid) begin
			err_proto++;
			$display("response valid for %h stayed high for more than one cycle", addr);
		end
	endtask

	task automatic run_trace(input int fd);
		logic [7:0]        op;
		logic [31:0]       a, b, c, d, e;
		logic [8*128-1:0]  line;
		arc_pkg::cpu_rsp_t rsp;
		arc_pkg::cpu_rsp_t exp;
		int                n;
		logic              done;
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, " %s", op);
			if (n != 1) begin
				done = 1'b1;
			end else begin
				case (op)
					"#": n = $fgets(line, fd);
					"W": begin
						n = $fscanf(fd, " %h %h", a, b);
						bus_access(a, 1'b1, b, rsp);
					end
					"R": begin
						n = $fscanf(fd, " %h %h %h", a, b, c);
						bus_access(a, 1'b0, 32'h0, rsp);
						exp.rdata = b;
						exp.err = c[0];
						check_rsp(rsp, exp, a);
					end
					"F": begin
						@(posedge clk);
						flybk <= 1'b1;
						repeat (SYNC_STAGES + 2) @(posedge clk);
						flybk <= 1'b0;
					end
					"K": begin
						n = $fscanf(fd, " %h", a);
						@(posedge clk);
						kbd_in_data <= a[7:0];
						kbd_in_strobe <= 1'b1;
						@(posedge clk);
						kbd_in_strobe <= 1'b0;
						repeat (2) @(posedge clk);
					end
					"J": begin
						n = $fscanf(fd, " %h %h", a, b);
						@(posedge clk);
						joy0 <= a[4:0];
						joy1 <= b[4:0];
					end
					"D": begin
						n = $fscanf(fd, " %h %h", a, b);
						@(posedge clk);
						floppy_drq <= a[0];
						floppy_irq <= b[0];
						repeat (2) @(posedge clk);
					end
					"I": begin
						n = $fscanf(fd, " %h %h", a, b);
						@(negedge clk);
						check_irq({irq, firq}, {a[0], b[0]});
					end
					"O": begin
						n = $fscanf(fd, " %h %h %h %h %h", a, b, c, d, e);
						@(negedge clk);
						check_outputs({vidbaseclk, vidsyncpol, debug_led, i2c_clock, i2c_dout},
							{a[1:0], b[1:0], c[0], d[0], e[0]});
					end
					"T": begin
						n = $fscanf(fd, " %h", a);
						@(negedge clk);
						check_kbd(last_tx, a[7:0], tx_strobes);
						tx_strobes = 0;
					end
					default: begin
						err_proto++;
						$display("unknown trace operation %s", op);
						n = $fgets(line, fd);
					end
				endcase
			end
		end
	endtask

	initial begin
		int fd;
		int n;
		int lines;
		logic [8*128-1:0] line;
		rst <= 1'b1;
		cpu_valid <= 1'b0;
		cpu_req <= '0;
		flybk <= 1'b0;
		floppy_drq <= 1'b0;
		floppy_irq <= 1'b0;
		kbd_in_data <= 8'h00;
		kbd_in_strobe <= 1'b0;
		i2c_din <= 1'b1;
		joy0 <= 5'h00;
		joy1 <= 5'h00;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_reset_state({cpu_ready, cpu_rsp_valid, mem_valid, kbd_out_strobe});
		check_irq({irq, firq}, 2'b00);

		// line count sets the watchdog limit
		lines = 0;
		fd = $fopen("test/arc_io_trace.txt", "r");
		if (fd == 0) begin
			err_proto++;
			$display("could not open the trace file test/arc_io_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0)
					lines++;
			end
			$fclose(fd);
			trace_lines = lines;
			fd = $fopen("test/arc_io_trace.txt", "r");
			run_trace(fd);
			$fclose(fd);
		end

		repeat (4) @(posedge clk);
		print_counts();
		if (err_rsp + err_irq + err_out + err_kbd + err_proto == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		wait (trace_lines != 0);
		repeat (trace_lines * CYCLES_PER_LINE) @(posedge clk);
		$display("watchdog expired after %0d cycles with the trace unfinished",
			trace_lines * CYCLES_PER_LINE);
		print_counts();
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
